// File: design/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// machine mode csr addresses
`define CSR_MSTATUS 12'h300
`define CSR_MIE     12'h304
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342
`define CSR_MIP     12'h344

// imm field of mret, func3 is 0
`define CSR_MRET    12'h302

// mpp = 3 and sxl/uxl = 2, interrupts off
`define MSTATUS_RESET 64'h0000_000a_0000_1800

// trap causes, interrupt bit set for the timer
`define CAUSE_ECALL  64'd11
`define CAUSE_MTIMER 64'h8000_0000_0000_0007

// bit positions
`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7
`define MIE_MTIE     7

// clint register offsets
`define TMR_MTIMECMP 16'h4000
`define TMR_MTIME    16'hbff8

`endif

// File: design/trapPkg.sv
// shared types for the trap subsystem
package trapPkg;

    // register width, rv64
    parameter int XLEN = 64;

    // every csr and timer register
    typedef logic [XLEN-1:0] wordT;

    // func3 of a SYSTEM instruction
    typedef enum logic [2:0] {
        // ecall or mret, told apart by the csr field
        opPriv = 3'd0,
        opRw   = 3'd1,
        opRs   = 3'd2,
        opRc   = 3'd3,
        // immediate forms take zimm instead of rs1
        opRwi  = 3'd5,
        opRsi  = 3'd6,
        opRci  = 3'd7
    } csrOpT;

    // true for func3 codes that write a csr
    function automatic logic isCsrOp(input csrOpT op);
        logic hit;
        case (op)
            opRw, opRs, opRc: hit = 1'b1;
            opRwi, opRsi, opRci: hit = 1'b1;
            // opPriv and the reserved code 4
            default: hit = 1'b0;
        endcase
        return hit;
    endfunction

endpackage

// File: design/csrWriteAlu.sv
`timescale 1ns/1ns

// new csr value from old value and the func3 operation
module csrWriteAlu import trapPkg::*; (
    input  csrOpT      op,
    input  wordT       oldVal,
    input  wordT       rs1Data,
    input  logic [4:0] zimm,
    output wordT       newVal
);

    // selected source operand
    wordT operand;
    // zimm widened to a full word
    wordT immExt;

    // zero extend, no sign
    assign immExt = {{(XLEN-5){1'b0}}, zimm};

    // register forms use rs1
    always_comb begin
        case (op)
            opRw, opRs, opRc: begin
                operand = rs1Data;
            end
            // immediate forms
            default: begin
                operand = immExt;
            end
        endcase
    end

    // write, set or clear
    always_comb begin
        case (op)
            opRw, opRwi: begin
                newVal = operand;
            end
            opRs, opRsi: begin
                newVal = oldVal | operand;
            end
            opRc, opRci: begin
                // clear bits set in operand
                newVal = oldVal & ~operand;
            end
            // ecall/mret and reserved codes
            default: begin
                newVal = '0;
            end
        endcase
    end

endmodule

// File: design/csrTrapUnit.sv
`timescale 1ns/1ns
`include "csr_consts.svh"

// machine csr file with ecall, mret and timer interrupt handling
module csrTrapUnit import trapPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        intrEn,
    input  logic [11:0] csr,
    input  csrOpT       func3,
    input  wordT        rs1Data,
    input  logic [4:0]  zimm,
    input  wordT        pc,
    input  logic        mtip,
    output wordT        csrRdata,
    output logic        isIntrPc,
    output wordT        intrPc,
    output logic        trapTaken
);

    // csr state
    wordT mtvec;
    wordT mepc;
    wordT mcause;
    wordT mstatus;
    wordT mie;
    // built from mtip, not stored
    wordT mip;

    // address decode
    logic selMstatus;
    logic selMie;
    logic selMtvec;
    logic selMepc;
    logic selMcause;
    logic selMip;

    // instruction and trap decode
    logic isPriv;
    logic isEcall;
    logic isMret;
    logic timerIrq;
    logic trapEnter;
    logic doRet;
    logic csrWrite;

    // next values
    wordT newVal;
    wordT trapCause;
    wordT mstatusNext;

    assign selMstatus = (csr == `CSR_MSTATUS);
    assign selMie     = (csr == `CSR_MIE);
    assign selMtvec   = (csr == `CSR_MTVEC);
    assign selMepc    = (csr == `CSR_MEPC);
    assign selMcause  = (csr == `CSR_MCAUSE);
    assign selMip     = (csr == `CSR_MIP);

    // ecall and mret share func3 0
    assign isPriv  = intrEn & (func3 == opPriv);
    assign isEcall = isPriv & (csr == 12'h000);
    assign isMret  = isPriv & (csr == `CSR_MRET);

    // global and local enable both needed
    assign timerIrq = mtip & mstatus[`MSTATUS_MIE] & mie[`MIE_MTIE];

    // timer wins, instruction in that cycle is dropped
    assign trapEnter = timerIrq | isEcall;
    assign doRet     = isMret & ~timerIrq;
    assign csrWrite  = intrEn & isCsrOp(func3) & ~timerIrq;

    assign trapCause = timerIrq ? `CAUSE_MTIMER : `CAUSE_ECALL;

    // only the timer pending bit exists
    always_comb begin
        mip = '0;
        mip[`MIE_MTIE] = mtip;
    end

    // old value of the addressed csr
    always_comb begin
        if (selMstatus) begin
            csrRdata = mstatus;
        end else if (selMie) begin
            csrRdata = mie;
        end else if (selMtvec) begin
            csrRdata = mtvec;
        end else if (selMepc) begin
            csrRdata = mepc;
        end else if (selMcause) begin
            csrRdata = mcause;
        end else if (selMip) begin
            csrRdata = mip;
        end else begin
            // unimplemented address reads zero
            csrRdata = '0;
        end
    end

    csrWriteAlu csrWriteAlu_inst (
        .op      (func3),
        .oldVal  (csrRdata),
        .rs1Data (rs1Data),
        .zimm    (zimm),
        .newVal  (newVal)
    );

    // redirect on trap entry or return
    assign isIntrPc  = trapEnter | doRet;
    assign intrPc    = trapEnter ? mtvec : (doRet ? mepc : pc);
    assign trapTaken = trapEnter;

    // mie/mpie stack, trap pushes and mret pops
    always_comb begin
        mstatusNext = newVal;
        if (trapEnter) begin
            mstatusNext = mstatus;
            mstatusNext[`MSTATUS_MPIE] = mstatus[`MSTATUS_MIE];
            mstatusNext[`MSTATUS_MIE] = 1'b0;
        end else if (doRet) begin
            mstatusNext = mstatus;
            mstatusNext[`MSTATUS_MIE] = mstatus[`MSTATUS_MPIE];
            mstatusNext[`MSTATUS_MPIE] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= `MSTATUS_RESET;
        end else if (trapEnter || doRet || (csrWrite && selMstatus)) begin
            mstatus <= mstatusNext;
        end
    end

    // trap entry overrides a csr write
    always_ff @(posedge clk) begin
        if (rst) begin
            mepc <= '0;
        end else if (trapEnter) begin
            mepc <= pc;
        end else if (csrWrite && selMepc) begin
            mepc <= newVal;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcause <= '0;
        end else if (trapEnter) begin
            mcause <= trapCause;
        end else if (csrWrite && selMcause) begin
            mcause <= newVal;
        end
    end

    // direct mode only, written as is
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec <= '0;
        end else if (csrWrite && selMtvec) begin
            mtvec <= newVal;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mie <= '0;
        end else if (csrWrite && selMie) begin
            mie <= newVal;
        end
    end

endmodule

// File: design/clintTimer.sv
`timescale 1ns/1ns
`include "csr_consts.svh"

// core local timer, mtime counter and mtimecmp compare
module clintTimer import trapPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        tmrWen,
    input  logic [15:0] tmrAddr,
    input  wordT        tmrWdata,
    output wordT        tmrRdata,
    output logic        mtip
);

    // timer registers
    wordT mtime;
    wordT mtimecmp;

    // register port decode
    logic selMtime;
    logic selMtimecmp;
    logic wrMtime;
    logic wrMtimecmp;

    assign selMtime    = (tmrAddr == `TMR_MTIME);
    assign selMtimecmp = (tmrAddr == `TMR_MTIMECMP);
    assign wrMtime     = tmrWen & selMtime;
    assign wrMtimecmp  = tmrWen & selMtimecmp;

    // free running, a write takes the place of the increment
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime <= '0;
        end else if (wrMtime) begin
            mtime <= tmrWdata;
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    // all ones keeps mtip low out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp <= '1;
        end else if (wrMtimecmp) begin
            mtimecmp <= tmrWdata;
        end
    end

    // read mux
    always_comb begin
        if (selMtime) begin
            tmrRdata = mtime;
        end else if (selMtimecmp) begin
            tmrRdata = mtimecmp;
        end else begin
            // unmapped offset
            tmrRdata = '0;
        end
    end

    // pending level, unsigned compare
    assign mtip = (mtime >= mtimecmp);

endmodule

// File: design/trapSubsys.sv
`timescale 1ns/1ns

// trap/csr block plus the clint timer feeding it
module trapSubsys import trapPkg::*; (
    input  logic        clk,
    input  logic        rst,
    // core side, one SYSTEM instruction per cycle
    input  logic        intrEn,
    input  logic [11:0] csr,
    input  csrOpT       func3,
    input  wordT        rs1Data,
    input  logic [4:0]  zimm,
    input  wordT        pc,
    output wordT        csrRdata,
    output logic        isIntrPc,
    output wordT        intrPc,
    output logic        trapTaken,
    // timer register port
    input  logic        tmrWen,
    input  logic [15:0] tmrAddr,
    input  wordT        tmrWdata,
    output wordT        tmrRdata
);

    // timer pending level into the trap unit
    logic mtip;

    csrTrapUnit csrTrapUnit_inst (
        .clk       (clk),
        .rst       (rst),
        .intrEn    (intrEn),
        .csr       (csr),
        .func3     (func3),
        .rs1Data   (rs1Data),
        .zimm      (zimm),
        .pc        (pc),
        .mtip      (mtip),
        .csrRdata  (csrRdata),
        .isIntrPc  (isIntrPc),
        .intrPc    (intrPc),
        .trapTaken (trapTaken)
    );

    // single master on the timer port
    clintTimer clintTimer_inst (
        .clk      (clk),
        .rst      (rst),
        .tmrWen   (tmrWen),
        .tmrAddr  (tmrAddr),
        .tmrWdata (tmrWdata),
        .tmrRdata (tmrRdata),
        .mtip     (mtip)
    );

endmodule

// File: test/trapSubsys_checker.sv
`timescale 1ns/1ns
`include "csr_consts.svh"

// assertions on the trap unit, attached by bind below
module trapSubsys_checker import trapPkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        intrEn,
    input logic [11:0] csr,
    input wordT        pc,
    input logic        timerIrq,
    input logic        isIntrPc,
    input logic        trapTaken,
    input wordT        mtvec,
    input wordT        mepc,
    input wordT        mcause,
    input wordT        mstatus,
    input wordT        mie
);

    // one of the six implemented addresses
    logic knownCsr;

    assign knownCsr = (csr == `CSR_MSTATUS) || (csr == `CSR_MIE) || (csr == `CSR_MTVEC) ||
                      (csr == `CSR_MEPC) || (csr == `CSR_MCAUSE) || (csr == `CSR_MIP);

    // trap entry saves the pc of the trapping cycle
    trapSavesPc: assert property (@(posedge clk) disable iff (rst)
        trapTaken |=> (mepc == $past(pc)))
        else $error("mepc does not hold the pc of the trap cycle");

    // trap entry masks further interrupts
    trapClearsMie: assert property (@(posedge clk) disable iff (rst)
        trapTaken |=> !mstatus[`MSTATUS_MIE])
        else $error("mstatus.MIE still set after trap entry");

    // no redirect without an instruction or an enabled timer
    noSpuriousRedirect: assert property (@(posedge clk) disable iff (rst)
        (!intrEn && !timerIrq) |-> !isIntrPc)
        else $error("isIntrPc raised with nothing pending");

    // state holds on an unknown address without trap or return
    unknownCsrNoWrite: assert property (@(posedge clk) disable iff (rst)
        (!knownCsr && !isIntrPc) |=> ($stable(mtvec) && $stable(mepc) && $stable(mcause)
            && $stable(mstatus) && $stable(mie)))
        else $error("csr state changed on an unknown address");

endmodule

bind csrTrapUnit trapSubsys_checker trapSubsys_checker_inst (
    .clk       (clk),
    .rst       (rst),
    .intrEn    (intrEn),
    .csr       (csr),
    .pc        (pc),
    .timerIrq  (timerIrq),
    .isIntrPc  (isIntrPc),
    .trapTaken (trapTaken),
    .mtvec     (mtvec),
    .mepc      (mepc),
    .mcause    (mcause),
    .mstatus   (mstatus),
    .mie       (mie)
);

// File: test/trapSubsys_tb.sv
`timescale 1ns/1ns
`include "csr_consts.svh"

// testbench for the trap subsystem with the csr table first and then the timer scenarios
module trapSubsys_tb import trapPkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DELAY = 10;
    // run bound from the test lengths
    localparam int TABLE_ROWS_MAX = 30;
    localparam int TIMER_WAIT_MAX = 200;
    localparam int SCENARIO_CYCLES = 170;
    localparam int MAX_CYCLES = TABLE_ROWS_MAX + TIMER_WAIT_MAX + SCENARIO_CYCLES;

    // handler address programmed by the table
    localparam wordT HANDLER = 64'h8000_0400;

    typedef struct {
        logic        en;
        logic [11:0] csr;
        csrOpT       op;
        wordT        rs1;
        logic [4:0]  zimm;
        wordT        pc;
        wordT        expRdata;
        logic        expIsIntr;
        wordT        expIntrPc;
    } rowT;

    logic        clk;
    logic        rst;
    logic        intrEn;
    logic [11:0] csr;
    csrOpT       func3;
    wordT        rs1Data;
    logic [4:0]  zimm;
    wordT        pc;
    wordT        csrRdata;
    logic        isIntrPc;
    wordT        intrPc;
    logic        trapTaken;
    logic        tmrWen;
    logic [15:0] tmrAddr;
    wordT        tmrWdata;
    wordT        tmrRdata;

    rowT rows[$];
    int  errCount;
    int  checkCount;
    int  cycleCount;

    trapSubsys trapSubsys_inst (
        .clk       (clk),
        .rst       (rst),
        .intrEn    (intrEn),
        .csr       (csr),
        .func3     (func3),
        .rs1Data   (rs1Data),
        .zimm      (zimm),
        .pc        (pc),
        .csrRdata  (csrRdata),
        .isIntrPc  (isIntrPc),
        .intrPc    (intrPc),
        .trapTaken (trapTaken),
        .tmrWen    (tmrWen),
        .tmrAddr   (tmrAddr),
        .tmrWdata  (tmrWdata),
        .tmrRdata  (tmrRdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic expectWord(input string name, input wordT got, input wordT exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expectBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic addRow(input logic en, input logic [11:0] addr, input csrOpT op,
                          input wordT rs1, input logic [4:0] imm, input wordT p,
                          input wordT expRd, input logic expIs, input wordT expPc);
        rowT r;
        r.en = en;
        r.csr = addr;
        r.op = op;
        r.rs1 = rs1;
        r.zimm = imm;
        r.pc = p;
        r.expRdata = expRd;
        r.expIsIntr = expIs;
        r.expIntrPc = expPc;
        rows.push_back(r);
    endtask

    // next drive slot with the strobes dropped
    task automatic nextCycle();
        @(posedge clk);
        #DRIVE_DELAY;
        intrEn = 1'b0;
        tmrWen = 1'b0;
    endtask

    task automatic writeTimer(input logic [15:0] addr, input wordT data);
        nextCycle();
        tmrWen = 1'b1;
        tmrAddr = addr;
        tmrWdata = data;
    endtask

    task automatic issueCsr(input logic [11:0] addr, input csrOpT op, input wordT rs1,
                            input logic [4:0] imm);
        nextCycle();
        intrEn = 1'b1;
        csr = addr;
        func3 = op;
        rs1Data = rs1;
        zimm = imm;
    endtask

    // read only with intrEn low
    task automatic selectCsr(input logic [11:0] addr);
        nextCycle();
        csr = addr;
    endtask

    // expected values worked out by hand from the csr rules
    task automatic buildTable();
        // rw, rs, rc and the immediate forms on mtvec
        addRow(1'b1, `CSR_MTVEC, opRw, 64'h8000_0100, 5'h00, 64'h100, 64'h0, 1'b0, 64'h100);
        addRow(1'b1, `CSR_MTVEC, opRs, 64'h30, 5'h00, 64'h104, 64'h8000_0100, 1'b0, 64'h104);
        addRow(1'b1, `CSR_MTVEC, opRc, 64'h100, 5'h00, 64'h108, 64'h8000_0130, 1'b0, 64'h108);
        // zimm must win over the rs1 junk
        addRow(1'b1, `CSR_MTVEC, opRwi, 64'hdead, 5'h1c, 64'h10c, 64'h8000_0030, 1'b0, 64'h10c);
        addRow(1'b1, `CSR_MTVEC, opRsi, 64'hbeef, 5'h03, 64'h110, 64'h1c, 1'b0, 64'h110);
        addRow(1'b1, `CSR_MTVEC, opRci, 64'h0, 5'h0a, 64'h114, 64'h1f, 1'b0, 64'h114);
        addRow(1'b1, `CSR_MTVEC, opRw, HANDLER, 5'h00, 64'h118, 64'h15, 1'b0, 64'h118);
        // same forms on mie
        addRow(1'b1, `CSR_MIE, opRw, '1, 5'h00, 64'h11c, 64'h0, 1'b0, 64'h11c);
        addRow(1'b1, `CSR_MIE, opRc, 64'hffff_ffff_ffff_ff00, 5'h00, 64'h120, '1, 1'b0, 64'h120);
        addRow(1'b1, `CSR_MIE, opRci, 64'h0, 5'h0f, 64'h124, 64'hff, 1'b0, 64'h124);
        addRow(1'b1, `CSR_MIE, opRsi, 64'h0, 5'h01, 64'h128, 64'hf0, 1'b0, 64'h128);
        addRow(1'b1, `CSR_MIE, opRwi, 64'h0, 5'h00, 64'h12c, 64'hf1, 1'b0, 64'h12c);
        addRow(1'b1, `CSR_MIE, opRs, 64'h0a, 5'h00, 64'h13c, 64'h0, 1'b0, 64'h13c);
        // mip ignores the write
        addRow(1'b1, `CSR_MIP, opRw, '1, 5'h00, 64'h130, 64'h0, 1'b0, 64'h130);
        addRow(1'b1, `CSR_MIP, opRs, 64'h0, 5'h00, 64'h134, 64'h0, 1'b0, 64'h134);
        // set MIE and then ecall to the handler
        addRow(1'b1, `CSR_MSTATUS, opRsi, 64'h0, 5'h08, 64'h138,
               64'h000a_0000_1800, 1'b0, 64'h138);
        addRow(1'b1, 12'h000, opPriv, 64'h0, 5'h00, 64'h200, 64'h0, 1'b1, HANDLER);
        addRow(1'b1, `CSR_MEPC, opRs, 64'h0, 5'h00, HANDLER, 64'h200, 1'b0, HANDLER);
        addRow(1'b1, `CSR_MCAUSE, opRs, 64'h0, 5'h00, 64'h8000_0404, 64'd11, 1'b0, 64'h8000_0404);
        // MPIE took the old MIE
        addRow(1'b1, `CSR_MSTATUS, opRs, 64'h0, 5'h00, 64'h8000_0408,
               64'h000a_0000_1880, 1'b0, 64'h8000_0408);
        // mret back to mepc with MPIE set
        addRow(1'b1, `CSR_MRET, opPriv, 64'h0, 5'h00, 64'h8000_040c, 64'h0, 1'b1, 64'h200);
        addRow(1'b1, `CSR_MSTATUS, opRc, 64'h80, 5'h00, 64'h204,
               64'h000a_0000_1888, 1'b0, 64'h204);
        // MPIE now clear so mret leaves MIE low
        addRow(1'b1, `CSR_MRET, opPriv, 64'h0, 5'h00, 64'h208, 64'h0, 1'b1, 64'h200);
        addRow(1'b1, `CSR_MSTATUS, opRs, 64'h0, 5'h00, 64'h200,
               64'h000a_0000_1880, 1'b0, 64'h200);
        // write ignored without intrEn
        addRow(1'b0, `CSR_MTVEC, opRw, 64'h1234, 5'h00, 64'h204, HANDLER, 1'b0, 64'h204);
        addRow(1'b1, 12'h7c0, opRw, '1, 5'h00, 64'h208, 64'h0, 1'b0, 64'h208);
        addRow(1'b1, `CSR_MTVEC, opRs, 64'h0, 5'h00, 64'h20c, HANDLER, 1'b0, 64'h20c);
    endtask

    task automatic applyRow(input int idx);
        rowT r;
        r = rows[idx];
        issueCsr(r.csr, r.op, r.rs1, r.zimm);
        intrEn = r.en;
        pc = r.pc;
        @(negedge clk);
        expectWord($sformatf("csrRdata row %0d", idx), csrRdata, r.expRdata);
        expectBit($sformatf("isIntrPc row %0d", idx), isIntrPc, r.expIsIntr);
        expectWord($sformatf("intrPc row %0d", idx), intrPc, r.expIntrPc);
    endtask

    task automatic timerPortScenario();
        wordT t0;
        wordT t1;
        nextCycle();
        tmrAddr = `TMR_MTIME;
        @(negedge clk);
        t0 = tmrRdata;
        nextCycle();
        nextCycle();
        @(negedge clk);
        t1 = tmrRdata;
        expectWord("tmrRdata mtime step", t1 - t0, 64'd2);
        writeTimer(`TMR_MTIMECMP, 64'h0000_0100_0000_0000);
        nextCycle();
        tmrAddr = `TMR_MTIMECMP;
        @(negedge clk);
        expectWord("tmrRdata mtimecmp", tmrRdata, 64'h0000_0100_0000_0000);
        nextCycle();
        tmrAddr = 16'h0008;
        @(negedge clk);
        expectWord("tmrRdata unknown", tmrRdata, 64'h0);
    endtask

    // mtip high and MTIE set but MIE still clear
    task automatic maskedTimerScenario();
        int i;
        writeTimer(`TMR_MTIMECMP, 64'd5);
        issueCsr(`CSR_MIE, opRs, 64'h80, 5'h00);
        @(negedge clk);
        expectWord("csrRdata mie", csrRdata, 64'h0a);
        expectBit("isIntrPc mie write", isIntrPc, 1'b0);
        for (i = 0; i < 10; i++) begin
            selectCsr(`CSR_MIP);
            @(negedge clk);
            expectWord("csrRdata mip", csrRdata, 64'h80);
            expectBit("isIntrPc masked", isIntrPc, 1'b0);
        end
    endtask

    task automatic timerTrapScenario();
        wordT trapPc;
        int   waitCycles;
        int   trapCount;
        logic seen;
        int   i;
        writeTimer(`TMR_MTIMECMP, 64'd20);
        writeTimer(`TMR_MTIME, 64'd0);
        issueCsr(`CSR_MSTATUS, opRsi, 64'h0, 5'h08);
        @(negedge clk);
        expectWord("csrRdata mstatus", csrRdata, 64'h000a_0000_1880);
        seen = 1'b0;
        waitCycles = 0;
        trapCount = 0;
        trapPc = '0;
        // core idles while the pc walks
        while (!seen && waitCycles < TIMER_WAIT_MAX) begin
            nextCycle();
            pc = 64'h3000 + wordT'(waitCycles * 4);
            @(negedge clk);
            waitCycles++;
            if (trapTaken) begin
                trapCount++;
            end
            if (isIntrPc) begin
                seen = 1'b1;
                trapPc = pc;
                expectWord("intrPc timer", intrPc, HANDLER);
            end
        end
        if (!seen) begin
            errCount++;
            $display("timer interrupt not taken within %0d cycles", TIMER_WAIT_MAX);
        end else begin
            // mtip stays high while MIE is now low
            for (i = 0; i < 10; i++) begin
                nextCycle();
                pc = pc + 64'd4;
                @(negedge clk);
                if (trapTaken) begin
                    trapCount++;
                end
                expectBit("isIntrPc after trap", isIntrPc, 1'b0);
            end
            expectWord("trapTaken pulse count", wordT'(trapCount), 64'd1);
            selectCsr(`CSR_MCAUSE);
            @(negedge clk);
            expectWord("csrRdata mcause", csrRdata, 64'h8000_0000_0000_0007);
            selectCsr(`CSR_MEPC);
            @(negedge clk);
            expectWord("csrRdata mepc", csrRdata, trapPc);
            selectCsr(`CSR_MSTATUS);
            @(negedge clk);
            expectWord("csrRdata mstatus after trap", csrRdata, 64'h000a_0000_1880);
        end
    endtask

    initial begin
        rst = 1'b1;
        intrEn = 1'b0;
        csr = '0;
        func3 = opRs;
        rs1Data = '0;
        zimm = '0;
        pc = '0;
        tmrWen = 1'b0;
        tmrAddr = '0;
        tmrWdata = '0;
        errCount = 0;
        checkCount = 0;
        buildTable();
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        foreach (rows[i]) begin
            applyRow(i);
        end
        timerPortScenario();
        maskedTimerScenario();
        timerTrapScenario();
        nextCycle();
        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // run limit
    initial begin
        cycleCount = 0;
        while (cycleCount < MAX_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("simulation ran past %0d cycles without finishing", MAX_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: sim.f
+incdir+design
design/trapPkg.sv
design/csrWriteAlu.sv
design/csrTrapUnit.sv
design/clintTimer.sv
design/trapSubsys.sv
test/trapSubsys_checker.sv
test/trapSubsys_tb.sv

// File: Makefile
# Verilator build and run of the trap subsystem testbench

VERILATOR ?= verilator
TOP       ?= trapSubsys_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK

.PHONY: sim clean

# pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
